// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define XLEN        32
`define REG_ADDR_W  5
`define RESET_PC    32'd2048

// Major opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111

// ALU funct3
`define F3_ADD_SUB  3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// Load and store widths shared by both formats
`define F3_B        3'b000
`define F3_H        3'b001
`define F3_W        3'b010
`define F3_BU       3'b100
`define F3_HU       3'b101

// Branch compares
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`endif

// File: rtl/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR, ALU_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } branch_cond_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_IMM, WB_LINK
    } wb_sel_e;

    typedef struct packed {
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        word_t        imm;
        alu_op_e      alu_op;
        logic         use_imm;      // ALU b from imm instead of rs2
        logic         reg_write;
        wb_sel_e      wb_sel;
        logic         mem_read;
        logic         mem_write;
        mem_size_e    mem_size;
        logic         load_unsigned;
        branch_cond_e branch;
    } ctrl_t;

    typedef struct packed {
        word_t     addr;
        word_t     wdata;
        mem_size_e size;
        logic      we;
        logic      re;
    } mem_req_t;

endpackage

// File: rtl/instr_decoder.sv
`include "core_defines.svh"

module instr_decoder (
    input  core_pkg::word_t instr,
    output core_pkg::ctrl_t ctrl
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_alt;     // Selects SUB and SRA
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            `F3_ADD_SUB: alu_sel = alt ? ALU_SUB : ALU_ADD;
            `F3_SLL:     alu_sel = ALU_SLL;
            `F3_SLT:     alu_sel = ALU_SLT;
            `F3_SLTU:    alu_sel = ALU_SLTU;
            `F3_XOR:     alu_sel = ALU_XOR;
            `F3_SRL_SRA: alu_sel = alt ? ALU_SRA : ALU_SRL;
            `F3_OR:      alu_sel = ALU_OR;
            default:     alu_sel = ALU_AND;
        endcase
    endfunction

    assign opcode     = instr[6:0];
    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl               = '0;
        ctrl.rs1           = instr[19:15];
        ctrl.rs2           = instr[24:20];
        ctrl.rd            = instr[11:7];
        ctrl.alu_op        = ALU_ADD;
        ctrl.wb_sel        = WB_ALU;
        ctrl.branch        = BR_NONE;
        ctrl.mem_size      = funct3[1] ? MEM_WORD : (funct3[0] ? MEM_HALF : MEM_BYTE);
        ctrl.load_unsigned = funct3[2];
        case (opcode)
            `OPC_OP: begin
                ctrl.alu_op    = alu_sel(funct3, funct7_alt);
                ctrl.reg_write = 1'b1;
            end
            `OPC_OP_IMM: begin
                // Bit 30 is part of the immediate except for SRAI
                ctrl.alu_op    = alu_sel(funct3, (funct3 == `F3_SRL_SRA) && funct7_alt);
                ctrl.imm       = imm_i;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            `OPC_LUI: begin
                ctrl.imm       = imm_u;
                ctrl.wb_sel    = WB_IMM;
                ctrl.reg_write = 1'b1;
            end
            `OPC_LOAD: begin
                ctrl.imm       = imm_i;
                ctrl.use_imm   = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            `OPC_STORE: begin
                ctrl.imm       = imm_s;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            `OPC_BRANCH: begin
                ctrl.imm = imm_b;
                case (funct3)
                    `F3_BEQ:  ctrl.branch = BR_EQ;
                    `F3_BNE:  ctrl.branch = BR_NE;
                    `F3_BLT:  ctrl.branch = BR_LT;
                    `F3_BGE:  ctrl.branch = BR_GE;
                    `F3_BLTU: ctrl.branch = BR_LTU;
                    `F3_BGEU: ctrl.branch = BR_GEU;
                    default:  ctrl.branch = BR_NONE;
                endcase
            end
            `OPC_JAL: begin
                ctrl.imm       = imm_j;
                ctrl.branch    = BR_JUMP;
                ctrl.wb_sel    = WB_LINK;   // rd gets pc + 4
                ctrl.reg_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`include "core_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] waddr,
    input  logic [`XLEN-1:0]       wdata,
    input  logic [`REG_ADDR_W-1:0] raddr0,
    output logic [`XLEN-1:0]       rdata0,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    output logic [`XLEN-1:0]       rdata1
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads with x0 hardwired to zero
    assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: rtl/alu.sv
module alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    output core_pkg::word_t   result
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            default:  result = a + b;
        endcase
    end

endmodule

// File: rtl/pc_unit.sv
`include "core_defines.svh"

module pc_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  core_pkg::branch_cond_e  cond,
    input  core_pkg::word_t         rs1_data,
    input  core_pkg::word_t         rs2_data,
    input  core_pkg::word_t         imm,
    output core_pkg::word_t         pc,
    output core_pkg::word_t         link
);
    import core_pkg::*;

    logic  taken;
    word_t next_pc;

    always_comb begin
        case (cond)
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  taken = (rs1_data < rs2_data);
            BR_GEU:  taken = (rs1_data >= rs2_data);
            BR_JUMP: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign link    = pc + 32'd4;
    assign next_pc = taken ? (pc + imm) : link;    // Target is pc relative

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: rtl/load_store_unit.sv
module load_store_unit (
    input  logic               rst,
    input  core_pkg::ctrl_t    ctrl,
    input  core_pkg::word_t    addr,
    input  core_pkg::word_t    store_data,
    input  core_pkg::word_t    rdata,
    output core_pkg::mem_req_t req,
    output core_pkg::word_t    load_data
);
    import core_pkg::*;

    logic sign_b;
    logic sign_h;

    always_comb begin
        req.addr = addr;
        req.size = ctrl.mem_size;
        case (ctrl.mem_size)
            MEM_BYTE: req.wdata = {24'b0, store_data[7:0]};
            MEM_HALF: req.wdata = {16'b0, store_data[15:0]};
            default:  req.wdata = store_data;
        endcase
        // No memory traffic while the core is held in reset
        req.we = ctrl.mem_write & ~rst;
        req.re = ctrl.mem_read & ~rst;
    end

    assign sign_b = rdata[7] & ~ctrl.load_unsigned;
    assign sign_h = rdata[15] & ~ctrl.load_unsigned;

    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: load_data = {{24{sign_b}}, rdata[7:0]};
            MEM_HALF: load_data = {{16{sign_h}}, rdata[15:0]};
            default:  load_data = rdata;
        endcase
    end

endmodule

// File: rtl/rv_core.sv
module rv_core (
    input  logic                clk,
    input  logic                rst,
    output core_pkg::word_t     instr_addr,
    input  core_pkg::word_t     instr,
    output core_pkg::word_t     data_addr,
    output core_pkg::word_t     data_wdata,
    output core_pkg::mem_size_e data_size,
    output logic                data_we,
    output logic                data_re,
    input  core_pkg::word_t     data_rdata
);
    import core_pkg::*;

    ctrl_t    ctrl;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    alu_b;
    word_t    alu_result;
    word_t    pc;
    word_t    link;
    word_t    load_data;
    word_t    wb_data;
    mem_req_t req;
    logic     rf_we;

    instr_decoder u_decoder (.instr(instr), .ctrl(ctrl));

    assign rf_we = ctrl.reg_write & ~rst;

    reg_file u_regs (
        .clk(clk), .we(rf_we), .waddr(ctrl.rd), .wdata(wb_data),
        .raddr0(ctrl.rs1), .rdata0(rs1_data),
        .raddr1(ctrl.rs2), .rdata1(rs2_data)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu u_alu (.op(ctrl.alu_op), .a(rs1_data), .b(alu_b), .result(alu_result));

    pc_unit u_pc (
        .clk(clk), .rst(rst), .cond(ctrl.branch),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(ctrl.imm),
        .pc(pc), .link(link)
    );

    load_store_unit u_lsu (
        .rst(rst), .ctrl(ctrl), .addr(alu_result), .store_data(rs2_data),
        .rdata(data_rdata), .req(req), .load_data(load_data)
    );

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = load_data;
            WB_IMM:  wb_data = ctrl.imm;   // LUI
            WB_LINK: wb_data = link;
            default: wb_data = alu_result;
        endcase
    end

    assign instr_addr = pc;
    assign data_addr  = req.addr;
    assign data_wdata = req.wdata;
    assign data_size  = req.size;
    assign data_we    = req.we;
    assign data_re    = req.re;

endmodule

// File: verif/core_checker.sv
`include "core_defines.svh"

module core_checker (
    input  logic                clk,
    input  logic                rst,
    input  core_pkg::word_t     instr_addr,
    input  core_pkg::word_t     instr,
    input  core_pkg::word_t     data_addr,
    input  core_pkg::word_t     data_wdata,
    input  core_pkg::mem_size_e data_size,
    input  logic                data_we,
    input  logic                data_re,
    output int                  error_count,
    output int                  check_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    word_t      regs [32];      // Architectural copy with x0 never written
    logic [7:0] mem [1024];
    word_t      model_pc;
    word_t      next_pc;
    mem_req_t   exp_req;

    initial begin
        error_count = 0;
        check_count = 0;
        model_pc    = `RESET_PC;
        foreach (regs[i]) regs[i] = '0;
        foreach (mem[i]) mem[i] = '0;
    end

    function automatic word_t arith_result(input logic [2:0] f3, input logic alt,
                                           input word_t x, input word_t y);
        word_t r;
        case (f3)
            `F3_ADD_SUB: r = alt ? x - y : x + y;
            `F3_SLL:     r = x << y[4:0];
            `F3_SLT:     r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            `F3_SLTU:    r = (x < y) ? 32'd1 : 32'd0;
            `F3_XOR:     r = x ^ y;
            `F3_SRL_SRA: begin
                if (alt) begin
                    r = $signed(x) >>> y[4:0];
                end else begin
                    r = x >> y[4:0];
                end
            end
            `F3_OR:      r = x | y;
            default:     r = x & y;
        endcase
        return r;
    endfunction

    // Executes one instruction on the local state and returns the next pc
    function automatic word_t step_model(input word_t ins, input word_t pc,
                                         output mem_req_t req);
        logic [2:0] f3;
        reg_addr_t  rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      wb;
        word_t      ld;
        word_t      nxt;
        logic [9:0] ba;
        logic       wr;
        logic       taken;
        f3    = ins[14:12];
        rd    = ins[11:7];
        a     = regs[ins[19:15]];
        b     = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        req   = '0;
        wb    = '0;
        wr    = 1'b0;
        taken = 1'b0;
        nxt   = pc + 32'd4;
        case (ins[6:0])
            `OPC_OP: begin
                wb = arith_result(f3, ins[30], a, b);
                wr = 1'b1;
            end
            `OPC_OP_IMM: begin
                wb = arith_result(f3, ins[30] && (f3 == `F3_SRL_SRA), a, imm_i);
                wr = 1'b1;
            end
            `OPC_LUI: begin
                wb = {ins[31:12], 12'b0};
                wr = 1'b1;
            end
            `OPC_LOAD: begin
                req.addr = a + imm_i;
                req.re   = 1'b1;
                req.size = mem_size_e'(f3[1:0]);
                ba = req.addr[9:0];
                ld = {mem[ba + 10'd3], mem[ba + 10'd2], mem[ba + 10'd1], mem[ba]};
                case (f3)
                    `F3_B:   wb = {{24{ld[7]}}, ld[7:0]};
                    `F3_BU:  wb = {24'b0, ld[7:0]};
                    `F3_H:   wb = {{16{ld[15]}}, ld[15:0]};
                    `F3_HU:  wb = {16'b0, ld[15:0]};
                    default: wb = ld;
                endcase
                wr = 1'b1;
            end
            `OPC_STORE: begin
                req.addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                req.we   = 1'b1;
                req.size = mem_size_e'(f3[1:0]);
                case (f3)
                    `F3_B:   req.wdata = {24'b0, b[7:0]};
                    `F3_H:   req.wdata = {16'b0, b[15:0]};
                    default: req.wdata = b;
                endcase
                ba = req.addr[9:0];
                mem[ba] = b[7:0];
                if (f3 != `F3_B) begin
                    mem[ba + 10'd1] = b[15:8];
                end
                if (f3 == `F3_W) begin
                    mem[ba + 10'd2] = b[23:16];
                    mem[ba + 10'd3] = b[31:24];
                end
            end
            `OPC_BRANCH: begin
                case (f3)
                    `F3_BEQ:  taken = (a == b);
                    `F3_BNE:  taken = (a != b);
                    `F3_BLT:  taken = ($signed(a) < $signed(b));
                    `F3_BGE:  taken = ($signed(a) >= $signed(b));
                    `F3_BLTU: taken = (a < b);
                    `F3_BGEU: taken = (a >= b);
                    default:  taken = 1'b0;
                endcase
                if (taken) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            `OPC_JAL: begin
                wb  = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        if (wr && (rd != '0)) begin
            regs[rd] = wb;
        end
        return nxt;
    endfunction

    task automatic expect_value(input string name, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // Sampled mid-cycle once all outputs have settled
    always @(negedge clk) begin
        if (rst) begin
            expect_value("data_we", '0, data_we);
            expect_value("data_re", '0, data_re);
            model_pc = `RESET_PC;
        end else begin
            expect_value("instr_addr", model_pc, instr_addr);
            next_pc = step_model(instr, model_pc, exp_req);
            expect_value("data_we", exp_req.we, data_we);
            expect_value("data_re", exp_req.re, data_re);
            if (exp_req.we || exp_req.re) begin
                expect_value("data_addr", exp_req.addr, data_addr);
                expect_value("data_size", exp_req.size, data_size);
            end
            if (exp_req.we) begin
                expect_value("data_wdata", exp_req.wdata, data_wdata);
            end
            model_pc = next_pc;
        end
    end

endmodule

// File: verif/tb_core.sv
`include "core_defines.svh"

module tb_core;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int RUN_LIMIT = 2000;    // Cycles allowed per program

    logic        clk = 1'b0;
    logic        rst;
    word_t       instr_addr;
    word_t       instr;
    word_t       data_addr;
    word_t       data_wdata;
    mem_size_e   data_size;
    logic        data_we;
    logic        data_re;
    word_t       data_rdata;
    logic [9:0]  byte_addr;
    int          error_count;
    int          check_count;
    int          test_num;
    int          timeouts;
    logic [31:0] lcg_state;
    word_t       imem [256];
    logic [7:0]  dmem [1024];
    word_t       prog [$];

    rv_core DUT (.*);

    core_checker u_checker (.*);

    initial begin
        forever #5 clk = ~clk;
    end

    assign instr      = imem[instr_addr[9:2]];   // 2048 maps to word 0
    assign byte_addr  = data_addr[9:0];
    assign data_rdata = {dmem[byte_addr + 10'd3], dmem[byte_addr + 10'd2],
                         dmem[byte_addr + 10'd1], dmem[byte_addr]};

    always @(posedge clk) begin
        if (data_we) begin
            dmem[byte_addr] <= data_wdata[7:0];
            if (data_size != MEM_BYTE) begin
                dmem[byte_addr + 10'd1] <= data_wdata[15:8];
            end
            if (data_size == MEM_WORD) begin
                dmem[byte_addr + 10'd2] <= data_wdata[23:16];
                dmem[byte_addr + 10'd3] <= data_wdata[31:24];
            end
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2, rs1,
                                     input logic [2:0] f3, input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2, rs1,
                                     input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic word_t b_type(input logic [12:0] off, input reg_addr_t rs2, rs1,
                                     input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input logic [19:0] upper, input reg_addr_t rd);
        return {upper, rd, `OPC_LUI};
    endfunction

    function automatic word_t j_type(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    task automatic emit(input word_t w);
        prog.push_back(w);
    endtask

    task automatic add_immediate(input reg_addr_t rd, input reg_addr_t rs1,
                                 input logic [11:0] imm);
        emit(i_type(imm, rs1, `F3_ADD_SUB, rd, `OPC_OP_IMM));
    endtask

    task automatic store_word(input reg_addr_t rs, input logic [11:0] addr);
        emit(s_type(addr, rs, 5'd0, `F3_W));
    endtask

    // x1 = 0x87654321, x2 = -7, x3 = 5
    task automatic init_regs();
        emit(u_type(20'h87654, 5'd1));
        add_immediate(5'd1, 5'd1, 12'h321);
        add_immediate(5'd2, 5'd0, 12'hFF9);
        add_immediate(5'd3, 5'd0, 12'h005);
    endtask

    task automatic run_program(input string name);
        word_t end_addr;
        int    errs_before;
        int    cycles;
        errs_before = error_count;
        emit(j_type(21'd0, 5'd0));      // End marker jumps to itself
        end_addr = `RESET_PC + 4 * (prog.size() - 1);
        @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (imem[i]) imem[i] = (i < prog.size()) ? prog[i] : '0;
        prog.delete();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles = 0;
        while (instr_addr !== end_addr && cycles < RUN_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        test_num++;
        if (instr_addr !== end_addr) begin
            timeouts++;
            $display("test %0d (%s): program never reached its end address %h",
                     test_num, name, end_addr);
        end else if (error_count != errs_before) begin
            $display("test %0d (%s): failed with %0d errors", test_num, name,
                     error_count - errs_before);
        end else begin
            $display("test %0d (%s): passed in %0d cycles", test_num, name, cycles);
        end
    endtask

    task automatic alu_register_test();
        logic [2:0] f3s [10] = '{0, 0, 1, 5, 5, 2, 3, 7, 6, 4};
        logic [6:0] f7s [10] = '{0, 7'h20, 0, 0, 7'h20, 0, 0, 0, 0, 0};
        init_regs();
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 10; k++) begin
                emit(r_type(f7s[k], p ? 5'd1 : 5'd3, p ? 5'd2 : 5'd1, f3s[k], 5'd4));
                store_word(5'd4, 12'h100 + 4 * (k + 10 * p));
            end
        end
        run_program("register ALU ops");
    endtask

    task automatic alu_immediate_test();
        // Negative immediates written in 12-bit hex
        // 0x40d and 0x401 encode SRAI
        logic [11:0] imms [13] = '{12'hF9C, 12'h7FF, 12'hFFD, 12'hFF8, 12'h005, 12'hFFF,
                                   12'hFFF, 12'h0F0, 12'hF00, 12'h007, 12'h00D, 12'h40D,
                                   12'h401};
        logic [2:0]  f3s [13]  = '{0, 0, 2, 2, 3, 3, 4, 6, 7, 1, 5, 5, 5};
        reg_addr_t   srcs [13] = '{1, 2, 2, 2, 2, 3, 1, 2, 1, 1, 1, 1, 2};
        init_regs();
        for (int k = 0; k < 13; k++) begin
            emit(i_type(imms[k], srcs[k], f3s[k], 5'd5, `OPC_OP_IMM));
            store_word(5'd5, 12'h180 + 4 * k);
        end
        emit(u_type(20'hFFFFF, 5'd5));
        store_word(5'd5, 12'h1F4);
        emit(u_type(20'h00001, 5'd5));
        store_word(5'd5, 12'h1F8);
        run_program("immediate ops and LUI");
    endtask

    task automatic load_test();
        logic [2:0]  f3s [10]  = '{`F3_B, `F3_BU, `F3_H, `F3_H, `F3_HU, `F3_B, `F3_BU,
                                   `F3_W, `F3_W, `F3_W};
        logic [11:0] offs [10] = '{12'h200, 12'h200, 12'h200, 12'h202, 12'h202, 12'h203,
                                   12'h203, 12'h200, 12'h210, 12'h214};
        emit(i_type(12'h200, 5'd0, `F3_W, 5'd0, `OPC_LOAD));   // Load seen while rst is high
        emit(u_type(20'h8F7F0, 5'd7));
        add_immediate(5'd7, 5'd7, 12'h0E5);      // 0x8F7F00E5
        store_word(5'd7, 12'h200);
        emit(s_type(12'h210, 5'd7, 5'd0, `F3_B));
        emit(s_type(12'h214, 5'd7, 5'd0, `F3_H));
        for (int k = 0; k < 10; k++) begin
            emit(i_type(offs[k], 5'd0, f3s[k], 5'd8, `OPC_LOAD));
            store_word(5'd8, 12'h240 + 4 * k);
        end
        run_program("loads of each width");
    endtask

    task automatic branch_test();
        logic [2:0] f3s [6]  = '{`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
        reg_addr_t  t_a [6]  = '{3, 2, 2, 3, 3, 2};
        reg_addr_t  t_b [6]  = '{3, 3, 3, 2, 2, 3};
        reg_addr_t  n_a [6]  = '{2, 3, 3, 2, 2, 3};
        reg_addr_t  n_b [6]  = '{3, 3, 2, 3, 3, 2};
        init_regs();
        add_immediate(5'd9, 5'd0, 12'h000);
        for (int k = 0; k < 6; k++) begin
            emit(b_type(13'd8, t_b[k], t_a[k], f3s[k]));   // Skips the count
            add_immediate(5'd9, 5'd9, 12'h001);
            emit(b_type(13'd8, n_b[k], n_a[k], f3s[k]));
            add_immediate(5'd9, 5'd9, 12'h001);
        end
        add_immediate(5'd10, 5'd0, 12'h003);
        add_immediate(5'd10, 5'd10, 12'hFFF);
        emit(b_type(-13'sd4, 5'd0, 5'd10, `F3_BNE));        // Backward loop
        store_word(5'd9, 12'h2C0);
        store_word(5'd10, 12'h2C4);
        run_program("branches");
    endtask

    task automatic jump_test();
        store_word(5'd0, 12'h30C);                 // Sits at the reset vector
        emit(j_type(21'd12, 5'd10));
        add_immediate(5'd13, 5'd0, 12'h001);
        emit(j_type(21'd12, 5'd11));
        store_word(5'd10, 12'h300);
        emit(j_type(-21'sd8, 5'd12));
        store_word(5'd12, 12'h304);
        store_word(5'd11, 12'h308);
        run_program("JAL forward and backward");
    endtask

    task automatic random_test();
        logic [31:0] fields;
        logic [31:0] value;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        for (int r = 1; r < 8; r++) begin
            value = next_rand();
            emit(u_type(value[31:12], reg_addr_t'(r)));
            add_immediate(reg_addr_t'(r), reg_addr_t'(r), value[27:16]);
        end
        for (int n = 0; n < 48; n++) begin
            fields = next_rand();
            value  = next_rand();
            rd     = reg_addr_t'(1 + fields[29:27] % 7);
            rs1    = reg_addr_t'(1 + fields[26:24] % 7);
            rs2    = reg_addr_t'(1 + fields[23:21] % 7);
            f3     = fields[20:18];
            alt    = fields[17];
            imm    = value[31:20];
            case (fields[31:30])
                2'd0: begin
                    emit(r_type((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                                rs2, rs1, f3, rd));
                end
                2'd1: begin
                    if (f3 == `F3_SLL) begin
                        imm[11:5] = 7'h00;
                    end
                    if (f3 == `F3_SRL_SRA) begin
                        imm[11:5] = alt ? 7'h20 : 7'h00;
                    end
                    emit(i_type(imm, rs1, f3, rd, `OPC_OP_IMM));
                end
                2'd2: emit(s_type(12'h380 + {value[31:28], 2'b00}, rs2, 5'd0, f3 % 3));
                default: emit(u_type(value[31:12], rd));
            endcase
        end
        run_program("random program");
    endtask

    initial begin
        rst       = 1'b1;
        lcg_state = 32'd12907;
        test_num  = 0;
        timeouts  = 0;
        foreach (imem[i]) imem[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        alu_register_test();
        alu_immediate_test();
        load_test();
        branch_test();
        jump_test();
        random_test();
        $display("%0d tests, %0d checks, %0d errors, %0d timeouts",
                 test_num, check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/pc_unit.sv
rtl/load_store_unit.sv
rtl/rv_core.sv
verif/core_checker.sv
verif/tb_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - include
    files:
      - rtl/core_pkg.sv
      - rtl/instr_decoder.sv
      - rtl/reg_file.sv
      - rtl/alu.sv
      - rtl/pc_unit.sv
      - rtl/load_store_unit.sv
      - rtl/rv_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/core_checker.sv
      - verif/tb_core.sv
